// File: hdl/rom_check_pkg.sv
// ROM integrity checker definitions
package rom_check_pkg;

  // Default geometry of the checked ROM in 32-bit words
  parameter int unsigned RomDepthDefault = 64;

  // Default number of digest lanes and of expected digest words at the top of the ROM
  parameter int unsigned DigestLanesDefault = 4;

  // Lane k starts its fold from (k+1) times this constant
  parameter logic [31:0] LaneSeedBase = 32'h9E3779B9;

  // Control FSM encoding
  // Every pair of codes differs in at least three bits
  // A single flipped bit therefore never turns one legal state into another
  //
  //   ReadingLow  vs ReadingHigh 6   ReadingLow  vs Checking 5
  //   ReadingLow  vs Done        4   ReadingLow  vs Invalid  5
  //   ReadingHigh vs Checking    5   ReadingHigh vs Done     6
  //   ReadingHigh vs Invalid     3   Checking    vs Done     5
  //   Checking    vs Invalid     4   Done        vs Invalid  5
  typedef enum logic [7:0] {
    ReadingLow  = 8'b1011_0010,
    ReadingHigh = 8'b0110_1001,
    Checking    = 8'b1100_0111,
    Done        = 8'b0001_1110,
    Invalid     = 8'b1111_1101
  } fsm_state_e;

  // Status reported by the checker at the end of the boot-time run
  // done is held until reset once the run has finished
  // good is only ever high together with done
  // alert is held once the FSM has reached the invalid state
  typedef struct packed {
    logic done;
    logic good;
    logic alert;
  } rom_status_t;

endpackage

// File: hdl/wb_pkg.sv
// Wishbone classic read port types
package wb_pkg;

  // Master to slave signals
  // The port is read only so we stays low in every cycle
  // adr is a word address and not a byte address
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [15:0] adr;
  } wb_req_t;

  // Slave to master signals
  // dat is only meaningful in the cycle where ack is high
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: hdl/rom_read_seq.sv
// ROM read sequencer
`timescale 1ns/10ps

module rom_read_seq #(
  parameter int unsigned RomDepth    = rom_check_pkg::RomDepthDefault,
  parameter int unsigned DigestLanes = rom_check_pkg::DigestLanesDefault,
  // Derived widths of the word address and of the index into the top region
  localparam int unsigned AW  = $clog2(RomDepth),
  localparam int unsigned TAW = (DigestLanes > 1) ? $clog2(DigestLanes) : 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  wb_pkg::wb_rsp_t  wb_i,
  output wb_pkg::wb_req_t  wb_o,
  output logic [31:0]      word_o,
  output logic             word_valid_o,
  output logic             low_o,
  output logic             last_low_o,
  output logic [TAW-1:0]   top_idx_o,
  output logic             seq_done_o
);

  // First address of the expected digest and the last address of the ROM
  localparam logic [AW-1:0] TopStart = AW'(RomDepth - DigestLanes);
  localparam logic [AW-1:0] LastAddr = AW'(RomDepth - 1);

  logic [AW-1:0] addr_q;
  logic          busy_q;
  logic          done_q;
  logic          ack;

  // Acks are only taken while a bus cycle is open
  assign ack = busy_q & wb_i.ack;

  // The bus cycle opens on the first clock after reset and stays open for the whole sweep
  // On each ack the address steps and the next read is presented in the following cycle
  // After the ack of the last word cyc and stb drop and the sequencer stays done until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (ack) begin
      if (addr_q == LastAddr) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end else begin
        addr_q <= addr_q + 1'b1;
      end
    end else if (!busy_q && !done_q) begin
      busy_q <= 1'b1;
    end
  end

  // Classic read with strobe tied to the cycle and the address held stable until ack
  assign wb_o = '{cyc: busy_q, stb: busy_q, we: 1'b0, adr: 16'(addr_q)};

  // The returned word goes out in the same cycle as its ack
  assign word_o       = wb_i.dat;
  assign word_valid_o = ack;

  // Region flags decode the address that is being acked
  assign low_o      = (addr_q < TopStart);
  assign last_low_o = (addr_q == TopStart - 1'b1);

  // Offset into the expected digest words (meaningful only when low_o is low)
  assign top_idx_o = TAW'(addr_q - TopStart);

  assign seq_done_o = done_q;

endmodule

// File: hdl/digest_lane.sv
// Single digest lane
`timescale 1ns/10ps

module digest_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] word_i,
  input  logic        absorb_i,
  input  logic        last_i,
  output logic [31:0] digest_o,
  output logic        lane_done_o
);
  import rom_check_pkg::*;

  // Each lane has its own seed and rotation so that the lanes give different digests
  localparam logic [31:0] Seed = 32'((LaneIdx + 1) * LaneSeedBase);
  localparam int unsigned Rot  = (LaneIdx + 1) % 32;

  logic [31:0] state_q;
  logic [31:0] state_rot;
  logic        done_q;

  // Rotate left by Rot bits
  // A rotation of zero falls out as the plain state since the right shift by 32 gives zero
  assign state_rot = (state_q << Rot) | (state_q >> (32 - Rot));

  // The state restarts from the seed on every reset so each boot folds from scratch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Seed;
    end else if (absorb_i) begin
      state_q <= state_rot ^ word_i;
    end
  end

  // Done is set on the edge that absorbs the last low word and then held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (last_i) begin
      done_q <= 1'b1;
    end
  end

  assign digest_o    = state_q;
  assign lane_done_o = done_q;

endmodule

// File: hdl/digest_compare.sv
// Expected digest capture and compare
`timescale 1ns/10ps

module digest_compare #(
  parameter int unsigned DigestLanes = rom_check_pkg::DigestLanesDefault,
  localparam int unsigned TAW = (DigestLanes > 1) ? $clog2(DigestLanes) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [31:0]              word_i,
  input  logic                     top_valid_i,
  input  logic [TAW-1:0]           top_idx_i,
  input  logic [DigestLanes*32-1:0] lane_digest_i,
  input  logic                     start_i,
  output logic                     cmp_done_o,
  output logic                     cmp_good_o
);

  localparam logic [TAW-1:0] LastIdx = TAW'(DigestLanes - 1);

  // Expected digest words as read from the top of the ROM
  logic [31:0]    exp_q [DigestLanes];
  logic [TAW-1:0] idx_q;
  logic           running_q;
  logic           done_q;
  logic           good_q;
  logic           mismatch;

  // Top-region words land at their offset as they come off the bus
  always_ff @(posedge clk_i) begin
    if (top_valid_i) begin
      exp_q[top_idx_i] <= word_i;
    end
  end

  // One lane is compared per cycle while the compare runs
  assign mismatch = running_q && (lane_digest_i[idx_q*32 +: 32] != exp_q[idx_q]);

  // start_i arms the compare and sets good
  // The index then walks the lanes and any mismatch clears good for the rest of the run
  // Done pulses in the cycle after the last lane has been compared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q     <= '0;
      running_q <= 1'b0;
      done_q    <= 1'b0;
      good_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        idx_q     <= '0;
        running_q <= 1'b1;
        good_q    <= 1'b1;
      end else if (running_q) begin
        if (mismatch) begin
          good_q <= 1'b0;
        end
        if (idx_q == LastIdx) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  assign cmp_done_o = done_q;
  assign cmp_good_o = good_q;

endmodule

// File: hdl/rom_check_fsm.sv
// ROM check control FSM
`timescale 1ns/10ps

module rom_check_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       last_low_i,
  input  logic                       word_valid_i,
  input  logic                       seq_done_i,
  input  logic                       lanes_done_i,
  input  logic                       cmp_done_i,
  input  logic                       cmp_good_i,
  output logic                       check_start_o,
  output rom_check_pkg::rom_status_t status_o
);
  import rom_check_pkg::*;

  // The run is strictly linear
  //
  //   ReadingLow   the sequencer is reading the low region into the lanes
  //   ReadingHigh  the lanes are folded and the expected words are being read
  //   Checking     the compare block walks the lanes
  //   Done         terminal state with the result on the status outputs
  //   Invalid      terminal error state that holds the alert
  //
  // No state is ever left for an earlier one

  fsm_state_e state_d;
  fsm_state_e state_q;
  logic       start_q;
  logic       in_done;
  logic       state_legal;

  always_comb begin
    state_d = state_q;

    case (state_q)
      ReadingLow: begin
        // Leave as the final low word is acked
        if (word_valid_i && last_low_i) begin
          state_d = ReadingHigh;
        end
      end

      ReadingHigh: begin
        // Both the bus sweep and every lane must be finished
        if (seq_done_i && lanes_done_i) begin
          state_d = Checking;
        end
      end

      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end

      Done: begin
        // Terminal
      end

      default: begin
        // Invalid itself and any code that is not a legal state
        state_d = Invalid;
      end
    endcase

    // Consistency of the done signals with the current state
    // The compare may only finish while it is running
    // The sweep cannot end while the low region is still being read
    // Once done the sequencer must stay done so a dropped flag means the counter was disturbed
    if ((cmp_done_i && state_q != Checking) ||
        (seq_done_i && state_q == ReadingLow) ||
        (!seq_done_i && state_q == Done)) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ReadingLow;
    end else begin
      state_q <= state_d;
    end
  end

  // Single pulse in the first cycle spent in Checking
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
    end else begin
      start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  assign check_start_o = start_q;

  // Anything other than the four working states raises the alert
  // Invalid is terminal so the alert holds until reset
  assign state_legal = (state_q == ReadingLow) || (state_q == ReadingHigh) ||
                       (state_q == Checking) || (state_q == Done);
  assign in_done     = (state_q == Done);

  // Good shows the compare result only in Done, a state that is never reached with an alert
  assign status_o = '{done: in_done, good: in_done & cmp_good_i, alert: ~state_legal};

endmodule

// File: hdl/rom_check_top.sv
// ROM integrity checker top level
`timescale 1ns/10ps

module rom_check_top #(
  parameter int unsigned RomDepth    = rom_check_pkg::RomDepthDefault,
  parameter int unsigned DigestLanes = rom_check_pkg::DigestLanesDefault,
  localparam int unsigned TAW = (DigestLanes > 1) ? $clog2(DigestLanes) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  wb_pkg::wb_rsp_t            wb_i,
  output wb_pkg::wb_req_t            wb_o,
  output rom_check_pkg::rom_status_t status_o,
  output logic [DigestLanes*32-1:0]  digest_o
);

  logic [31:0]            word;
  logic                   word_valid;
  logic                   low;
  logic                   last_low;
  logic [TAW-1:0]         top_idx;
  logic                   seq_done;
  logic                   absorb;
  logic                   absorb_last;
  logic                   top_valid;
  logic [DigestLanes-1:0] lane_done;
  logic                   lanes_done;
  logic                   check_start;
  logic                   cmp_done;
  logic                   cmp_good;

  // Bus master that sweeps the whole ROM once per reset
  rom_read_seq #(
    .RomDepth    (RomDepth),
    .DigestLanes (DigestLanes)
  ) u_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_i         (wb_i),
    .wb_o         (wb_o),
    .word_o       (word),
    .word_valid_o (word_valid),
    .low_o        (low),
    .last_low_o   (last_low),
    .top_idx_o    (top_idx),
    .seq_done_o   (seq_done)
  );

  // Low words feed the lanes and top words feed the compare block
  assign absorb      = word_valid & low;
  assign absorb_last = word_valid & last_low;
  assign top_valid   = word_valid & ~low;

  // Every lane sees the same words and differs only in seed and rotation
  for (genvar k = 0; k < DigestLanes; k++) begin : g_lane
    digest_lane #(
      .LaneIdx (k)
    ) u_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .word_i      (word),
      .absorb_i    (absorb),
      .last_i      (absorb_last),
      .digest_o    (digest_o[k*32 +: 32]),
      .lane_done_o (lane_done[k])
    );
  end

  assign lanes_done = &lane_done;

  digest_compare #(
    .DigestLanes (DigestLanes)
  ) u_cmp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_i        (word),
    .top_valid_i   (top_valid),
    .top_idx_i     (top_idx),
    .lane_digest_i (digest_o),
    .start_i       (check_start),
    .cmp_done_o    (cmp_done),
    .cmp_good_o    (cmp_good)
  );

  rom_check_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .last_low_i    (last_low),
    .word_valid_i  (word_valid),
    .seq_done_i    (seq_done),
    .lanes_done_i  (lanes_done),
    .cmp_done_i    (cmp_done),
    .cmp_good_i    (cmp_good),
    .check_start_o (check_start),
    .status_o      (status_o)
  );

endmodule

// File: sim/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int unsigned HalfPeriodNs = 4,
  parameter int unsigned ResetCycles  = 16
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  // Reset is held while the counter is nonzero, so it starts asserted at time zero
  logic [7:0] cnt_q = 8'(ResetCycles);

  initial clk_o = 1'b0;
  always #(HalfPeriodNs) clk_o = ~clk_o;

  // A request restarts the reset for another full ResetCycles cycles
  always @(posedge clk_o) begin
    if (rst_req_i) begin
      cnt_q <= 8'(ResetCycles);
    end else if (cnt_q != 8'd0) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  assign rst_no = (cnt_q == 8'd0);

endmodule

// File: sim/rom_check_props.sv
// Wishbone and status properties
`timescale 1ns/10ps

module rom_check_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input wb_pkg::wb_req_t            wb_req_i,
  input wb_pkg::wb_rsp_t            wb_rsp_i,
  input rom_check_pkg::rom_status_t status_i
);

  // A strobe outside an open bus cycle is a protocol violation
  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_i.stb |-> wb_req_i.cyc)
    else $error("Wishbone stb is high while cyc is low");

  // The master must hold the address of a pending read until the slave acks it
  adr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_req_i.stb && !wb_rsp_i.ack) |=> $stable(wb_req_i.adr))
    else $error("Wishbone adr changed before ack");

  // A good result only exists at the end of a run
  good_needs_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_i.good |-> status_i.done)
    else $error("status good is high while done is low");

endmodule

// File: sim/rom_check_tb.sv
// ROM integrity checker testbench
`timescale 1ns/10ps

module rom_check_tb;
  import wb_pkg::*;
  import rom_check_pkg::*;

  localparam int unsigned RomDepth    = 64;
  localparam int unsigned DigestLanes = 4;
  localparam int unsigned AddrBits    = 6;
  localparam int unsigned TopStart    = RomDepth - DigestLanes;
  localparam int unsigned Rounds      = 8;
  localparam int unsigned HoldCycles  = 8;
  localparam logic [31:0] SeedBase    = 32'h9E3779B9;
  localparam logic [31:0] LfsrTaps    = 32'h8020_0003;
  // Each read takes two handshake cycles and up to three wait cycles
  // Reset, compare and the hold check add less than 40 cycles to every round
  localparam int unsigned TimeoutCycles = Rounds * (RomDepth * 5 + 40);

  logic                    clk;
  logic                    rst_n;
  logic                    rst_req = 1'b0;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp = '0;
  rom_status_t             status;
  logic [DigestLanes*32-1:0] digest;

  logic [31:0] rom_mem [RomDepth];
  logic [1:0]  delay_mem [RomDepth];
  logic [31:0] model_digest [DigestLanes];
  logic [31:0] lfsr_q = 32'd57;
  logic [1:0]  wait_q = 2'd0;
  logic        slave_busy_q = 1'b0;
  int          acks_seen = 0;
  int unsigned cycle_cnt = 0;

  tb_clkgen #(.HalfPeriodNs(4), .ResetCycles(16)) u_clkgen (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_no    (rst_n)
  );

  rom_check_top #(.RomDepth(RomDepth), .DigestLanes(DigestLanes)) dut0 (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_i     (wb_rsp),
    .wb_o     (wb_req),
    .status_o (status),
    .digest_o (digest)
  );

  bind rom_check_top rom_check_props u_props (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_o),
    .wb_rsp_i (wb_i),
    .status_i (status_o)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    report_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                             $time, name, got, exp));
  endtask

  // Galois LFSR stepped once for every random bit
  function automatic logic take_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) begin
      lfsr_q = lfsr_q ^ LfsrTaps;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  // Rotation done one bit at a time
  function automatic logic [31:0] rotate_left(input logic [31:0] v, input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], v[31]};
    end
    return v;
  endfunction

  // Fresh ROM contents, wait states and reference digests for one round
  task automatic prepare_round(input logic corrupt);
    int          widx;
    int          bpos;
    logic [31:0] s;
    for (int i = 0; i < RomDepth; i++) begin
      delay_mem[i] = 2'(rand_bits(2));
      if (i < TopStart) begin
        rom_mem[i] = rand_bits(32);
      end
    end
    // Lane k seeds with (k+1) times the base and rotates by k+1 before each XOR
    for (int k = 0; k < DigestLanes; k++) begin
      s = SeedBase * 32'(k + 1);
      for (int i = 0; i < TopStart; i++) begin
        s = rotate_left(s, k + 1) ^ rom_mem[i];
      end
      model_digest[k] = s;
      rom_mem[TopStart + k] = s;
    end
    if (corrupt) begin
      widx = int'(rand_bits(2));
      bpos = int'(rand_bits(5));
      rom_mem[TopStart + widx] = rom_mem[TopStart + widx] ^ (32'd1 << bpos);
    end
  endtask

  // Wishbone slave that inserts the wait states chosen for each address
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_rsp       <= '0;
      wait_q       <= 2'd0;
      slave_busy_q <= 1'b0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack   <= 1'b0;
      slave_busy_q <= 1'b0;
    end else if (!slave_busy_q && wb_req.cyc && wb_req.stb) begin
      if (delay_mem[wb_req.adr[AddrBits-1:0]] == 2'd0) begin
        wb_rsp.ack <= 1'b1;
        wb_rsp.dat <= rom_mem[wb_req.adr[AddrBits-1:0]];
      end else begin
        slave_busy_q <= 1'b1;
        wait_q       <= delay_mem[wb_req.adr[AddrBits-1:0]];
      end
    end else if (slave_busy_q) begin
      if (wait_q == 2'd1) begin
        wb_rsp.ack <= 1'b1;
        wb_rsp.dat <= rom_mem[wb_req.adr[AddrBits-1:0]];
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  // Bus monitor that samples mid-cycle where every signal has settled
  always @(negedge clk) begin
    if (!rst_n) begin
      acks_seen <= 0;
    end else begin
      if (wb_req.stb) begin
        assert (wb_req.cyc) else report_failure("Wishbone stb was raised without cyc");
      end
      if (wb_req.cyc) begin
        assert (!wb_req.we) else report_mismatch("wb_o.we", 32'(wb_req.we), 32'd0);
      end
      if (acks_seen == RomDepth) begin
        assert (!wb_req.cyc) else report_failure("Bus cycle still open after the last ack");
      end
      if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
        assert (wb_req.adr == 16'(acks_seen))
          else report_mismatch("wb_o.adr", 32'(wb_req.adr), 32'(acks_seen));
        acks_seen <= acks_seen + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure("Timeout: the checker did not finish all rounds in time");
    end
  end

  initial begin : main
    logic corrupt;
    logic good_q;
    for (int r = 0; r < Rounds; r++) begin
      if (r > 0) begin
        @(negedge clk) rst_req = 1'b1;
        @(negedge clk) rst_req = 1'b0;
      end
      wait (rst_n == 1'b0);
      // Odd rounds carry one flipped bit in the expected digest
      corrupt = (r % 2) == 1;
      prepare_round(corrupt);
      wait (rst_n == 1'b1);
      @(negedge clk);
      assert (!status.done) else report_mismatch("status_o.done", 32'(status.done), 32'd0);
      assert (!status.good) else report_mismatch("status_o.good", 32'(status.good), 32'd0);
      while (!status.done) begin
        assert (!status.alert) else report_mismatch("status_o.alert", 32'(status.alert), 32'd0);
        @(negedge clk);
      end
      assert (status.good == !corrupt)
        else report_mismatch("status_o.good", 32'(status.good), 32'(!corrupt));
      assert (acks_seen == RomDepth)
        else report_mismatch("read count", 32'(acks_seen), 32'(RomDepth));
      good_q = status.good;
      // Result must hold steady until the next reset
      repeat (HoldCycles) begin
        assert (status.done) else report_mismatch("status_o.done", 32'(status.done), 32'd1);
        assert (status.good == good_q)
          else report_mismatch("status_o.good", 32'(status.good), 32'(good_q));
        assert (!status.alert) else report_mismatch("status_o.alert", 32'(status.alert), 32'd0);
        for (int k = 0; k < DigestLanes; k++) begin
          assert (digest[k*32 +: 32] == model_digest[k])
            else report_mismatch($sformatf("digest_o[%0d]", k), digest[k*32 +: 32],
                                 model_digest[k]);
        end
        @(negedge clk);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// File: sim.f
hdl/rom_check_pkg.sv
hdl/wb_pkg.sv
hdl/rom_read_seq.sv
hdl/digest_lane.sv
hdl/digest_compare.sv
hdl/rom_check_fsm.sv
hdl/rom_check_top.sv
sim/tb_clkgen.sv
sim/rom_check_props.sv
sim/rom_check_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rom_check_tb -f sim.f -o rom_check_sim

out=$(./obj_dir/rom_check_sim 2>&1 || true)
echo "$out"
echo "$out" | grep -q "all tests passed"
